/* source/mmt_defines.svh */
`ifndef MMT_DEFINES_SVH
`define MMT_DEFINES_SVH

// element and matrix geometry
`define ELEM_W           8
`define MAX_DIM          8
`define DIM_W            3
`define NUM_MATS         8
`define MAT_W            3

// datapath widths
`define LANE_W           20
`define TERM_W           28
`define OUT_W            34

// queries served per load session
`define QUERIES_PER_LOAD 10

`endif

/* source/mmt_mem_pkg.sv */
`include "mmt_defines.svh"
`default_nettype none

package mmt_mem_pkg;

    typedef logic signed [`ELEM_W-1:0] elem_t;

    // ------------------------------------------------------------------
    // store address, seen two ways
    // ------------------------------------------------------------------
    // compute side walks row and col, load side steps a flat offset
    typedef union packed {
        struct packed {
            logic [`MAT_W-1:0] mat;
            logic [`DIM_W-1:0] row;
            logic [`DIM_W-1:0] col;
        } rc;
        struct packed {
            logic [`MAT_W-1:0]   mat;
            logic [2*`DIM_W-1:0] offset;
        } flat;
    } mat_addr_u;

endpackage

`default_nettype wire

/* source/mmt_ctrl_pkg.sv */
`default_nettype none

package mmt_ctrl_pkg;

    // query modes, encoding matches the mode port
    typedef enum logic [1:0] {
        MODE_AB_C  = 2'd0,
        MODE_ATB_C = 2'd1,
        MODE_ABT_C = 2'd2,
        MODE_AB_CT = 2'd3
    } mode_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,
        S_WAIT,
        S_QUEST,
        S_ROW,
        S_DRAIN
    } seq_state_e;

endpackage

`default_nettype wire

/* source/mmt_matrix_store.sv */
`include "mmt_defines.svh"
`default_nettype none

module mmt_matrix_store
    import mmt_mem_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr_en,
    input  mat_addr_u        wr_addr,
    input  elem_t            wr_data,
    input  logic [`DIM_W:0]  dim,
    input  mat_addr_u        rd_addr,
    output elem_t            rd_elem,
    input  mat_addr_u        vec_addr,
    input  logic             vec_transpose,
    output elem_t            vec_elems [`MAX_DIM]
);

    localparam int ADDR_W = `MAT_W + 2*`DIM_W;

    elem_t             mem [`NUM_MATS*`MAX_DIM*`MAX_DIM];
    logic [ADDR_W-1:0] vec_idx [`MAX_DIM];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[{wr_addr.flat.mat, wr_addr.flat.offset}] <= wr_data;
        end
    end

    // row read, or column read when transposed
    always_comb begin
        for (int j = 0; j < `MAX_DIM; j++) begin
            if (vec_transpose)
                vec_idx[j] = {vec_addr.rc.mat, (`DIM_W)'(j), vec_addr.rc.col};
            else
                vec_idx[j] = {vec_addr.rc.mat, vec_addr.rc.row, (`DIM_W)'(j)};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_elem <= '0;
            for (int j = 0; j < `MAX_DIM; j++) begin
                vec_elems[j] <= '0;
            end
        end else begin
            rd_elem <= mem[{rd_addr.rc.mat, rd_addr.rc.row, rd_addr.rc.col}];
            // lanes past the current size see zero
            for (int j = 0; j < `MAX_DIM; j++) begin
                vec_elems[j] <= (j < dim) ? mem[vec_idx[j]] : '0;
            end
        end
    end

endmodule

`default_nettype wire

/* source/mmt_sequencer.sv */
`include "mmt_defines.svh"
`default_nettype none

module mmt_sequencer
    import mmt_mem_pkg::*, mmt_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  elem_t             matrix,
    input  logic [1:0]        matrix_size,
    input  logic              in_valid2,
    input  logic [`MAT_W-1:0] matrix_idx,
    input  logic [1:0]        mode,
    output logic              wr_en,
    output mat_addr_u         wr_addr,
    output elem_t             wr_data,
    output logic [`DIM_W:0]   dim,
    output mat_addr_u         rd_addr,
    output mat_addr_u         vec_addr,
    output logic              vec_transpose,
    output logic              k_first,
    output logic              k_step,
    output logic              weight,
    output logic              row_last
);

    localparam int QCNT_W = $clog2(`QUERIES_PER_LOAD + 1);

    seq_state_e          state;
    mode_e               mode_q;
    logic [`MAT_W-1:0]   idx_a, idx_b, idx_c;
    logic [`DIM_W-1:0]   last, row_i, k_idx;
    logic [`DIM_W:0]     dim_code;
    logic [2*`DIM_W-1:0] row_skip;
    logic [QCNT_W-1:0]   query_cnt;
    logic                wt_phase, cap_second, drain_cnt;
    logic                iss_k, iss_w, a_t, b_t, c_t;
    mat_addr_u           next_wr;

    always_comb begin
        case (matrix_size)
            2'd0:    dim_code = (`DIM_W+1)'(2);
            2'd1:    dim_code = (`DIM_W+1)'(4);
            default: dim_code = (`DIM_W+1)'(`MAX_DIM);
        endcase
    end

    assign last     = dim[`DIM_W-1:0] - 1'b1;
    assign row_skip = (2*`DIM_W)'(`MAX_DIM) - (2*`DIM_W)'(last);

    // load walk: step the flat offset, jump the row gap, then next matrix
    always_comb begin
        next_wr = wr_addr;
        if (wr_addr.rc.col != last) begin
            next_wr.flat.offset = wr_addr.flat.offset + 1'b1;
        end else if (wr_addr.rc.row != last) begin
            next_wr.flat.offset = wr_addr.flat.offset + row_skip;
        end else begin
            next_wr.flat.mat    = wr_addr.flat.mat + 1'b1;
            next_wr.flat.offset = '0;
        end
    end

    //----------------------------------------------------------------------
    // main FSM
    //----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            dim        <= '0;
            wr_en      <= 1'b0;
            wr_addr    <= '0;
            mode_q     <= MODE_AB_C;
            idx_a      <= '0;
            idx_b      <= '0;
            idx_c      <= '0;
            row_i      <= '0;
            k_idx      <= '0;
            wt_phase   <= 1'b0;
            cap_second <= 1'b0;
            drain_cnt  <= 1'b0;
            query_cnt  <= '0;
        end else begin
            wr_en <= 1'b0;
            case (state)
                S_IDLE: begin
                    query_cnt <= '0;
                    if (in_valid) begin
                        dim     <= dim_code;
                        wr_en   <= 1'b1;
                        wr_addr <= '0;
                        state   <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    if (in_valid) begin
                        wr_en   <= 1'b1;
                        wr_addr <= next_wr;
                    end else begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (in_valid2) begin
                        mode_q     <= mode_e'(mode);
                        idx_a      <= matrix_idx;
                        cap_second <= 1'b0;
                        state      <= S_QUEST;
                    end
                end
                S_QUEST: begin
                    cap_second <= 1'b1;
                    if (!cap_second) begin
                        idx_b <= matrix_idx;
                    end else begin
                        idx_c     <= matrix_idx;
                        row_i     <= '0;
                        k_idx     <= '0;
                        wt_phase  <= 1'b0;
                        query_cnt <= query_cnt + 1'b1;
                        state     <= S_ROW;
                    end
                end
                S_ROW: begin
                    if (!wt_phase) begin
                        if (k_idx == last) wt_phase <= 1'b1;
                        else k_idx <= k_idx + 1'b1;
                    end else begin
                        wt_phase <= 1'b0;
                        k_idx    <= '0;
                        if (row_i == last) begin
                            drain_cnt <= 1'b0;
                            state     <= S_DRAIN;
                        end else begin
                            row_i <= row_i + 1'b1;
                        end
                    end
                end
                S_DRAIN: begin
                    // back in wait as the result pulse leaves
                    drain_cnt <= 1'b1;
                    if (drain_cnt) begin
                        if (query_cnt == QCNT_W'(`QUERIES_PER_LOAD)) state <= S_IDLE;
                        else state <= S_WAIT;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        wr_data <= matrix;
    end

    //----------------------------------------------------------------------
    // read addressing, strobes trail by the store latency
    //----------------------------------------------------------------------
    assign iss_k = (state == S_ROW) && !wt_phase;
    assign iss_w = (state == S_ROW) && wt_phase;
    assign a_t   = (mode_q == MODE_ATB_C);
    assign b_t   = (mode_q == MODE_ABT_C);
    assign c_t   = (mode_q == MODE_AB_CT);

    // op(A)[i][k]
    always_comb begin
        rd_addr.rc.mat = idx_a;
        rd_addr.rc.row = a_t ? k_idx : row_i;
        rd_addr.rc.col = a_t ? row_i : k_idx;
    end

    // op(B) row k, or C' row i on the weight step
    always_comb begin
        vec_addr.rc.mat = wt_phase ? idx_c : idx_b;
        vec_addr.rc.row = wt_phase ? row_i : k_idx;
        vec_addr.rc.col = wt_phase ? row_i : k_idx;
        vec_transpose   = wt_phase ? c_t : b_t;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            k_first  <= 1'b0;
            k_step   <= 1'b0;
            weight   <= 1'b0;
            row_last <= 1'b0;
        end else begin
            k_first  <= iss_k && (k_idx == '0);
            k_step   <= iss_k;
            weight   <= iss_w;
            row_last <= iss_w && (row_i == last);
        end
    end

endmodule

`default_nettype wire

/* source/mmt_dot_lane.sv */
`include "mmt_defines.svh"
`default_nettype none

module mmt_dot_lane (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic signed [`ELEM_W-1:0] a_elem,
    input  logic signed [`ELEM_W-1:0] b_elem,
    input  logic signed [`ELEM_W-1:0] c_elem,
    input  logic                      k_first,
    input  logic                      k_step,
    input  logic                      weight,
    input  logic                      row_last,
    output logic signed [`TERM_W-1:0] term,
    output logic                      term_valid,
    output logic                      term_last
);

    logic signed [`LANE_W-1:0] acc;

    // T[i][j], restarted on the first k of each row
    always_ff @(posedge clk) begin
        if (k_step) begin
            if (k_first) acc <= a_elem * b_elem;
            else acc <= acc + a_elem * b_elem;
        end
        if (weight) term <= acc * c_elem;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            term_valid <= 1'b0;
            term_last  <= 1'b0;
        end else begin
            term_valid <= weight;
            term_last  <= weight && row_last;
        end
    end

endmodule

`default_nettype wire

/* source/mmt_result_reducer.sv */
`include "mmt_defines.svh"
`default_nettype none

module mmt_result_reducer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic signed [`TERM_W-1:0] terms [`MAX_DIM],
    input  logic                      term_valid,
    input  logic                      term_last,
    output logic                      out_valid,
    output logic signed [`OUT_W-1:0]  out_value
);

    localparam int SUM_W = `TERM_W + $clog2(`MAX_DIM);

    logic signed [SUM_W-1:0]  row_sum;
    logic signed [`OUT_W-1:0] query_sum;

    // one row's worth of lane terms
    always_comb begin
        row_sum = '0;
        for (int j = 0; j < `MAX_DIM; j++) begin
            row_sum = row_sum + terms[j];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            query_sum <= '0;
            out_valid <= 1'b0;
            out_value <= '0;
        end else begin
            out_valid <= term_valid && term_last;
            out_value <= '0;
            if (term_valid) begin
                if (term_last) begin
                    out_value <= query_sum + row_sum;
                    query_sum <= '0;
                end else begin
                    query_sum <= query_sum + row_sum;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/mmt_top.sv */
`include "mmt_defines.svh"
`default_nettype none

module mmt_top
    import mmt_mem_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  elem_t                    matrix,
    input  logic [1:0]               matrix_size,
    input  logic                     in_valid2,
    input  logic [`MAT_W-1:0]        matrix_idx,
    input  logic [1:0]               mode,
    output logic                     out_valid,
    output logic signed [`OUT_W-1:0] out_value
);

    logic                      wr_en;
    mat_addr_u                 wr_addr;
    elem_t                     wr_data;
    logic [`DIM_W:0]           dim;
    mat_addr_u                 rd_addr;
    elem_t                     rd_elem;
    mat_addr_u                 vec_addr;
    logic                      vec_transpose;
    elem_t                     vec_elems [`MAX_DIM];
    logic                      k_first, k_step, weight, row_last;
    logic signed [`TERM_W-1:0] terms [`MAX_DIM];
    logic                      term_valid [`MAX_DIM];
    logic                      term_last [`MAX_DIM];

    mmt_sequencer i_sequencer (
        .clk, .rst_n,
        .in_valid, .matrix, .matrix_size,
        .in_valid2, .matrix_idx, .mode,
        .wr_en, .wr_addr, .wr_data, .dim,
        .rd_addr, .vec_addr, .vec_transpose,
        .k_first, .k_step, .weight, .row_last
    );

    mmt_matrix_store i_store (
        .clk, .rst_n,
        .wr_en, .wr_addr, .wr_data, .dim,
        .rd_addr, .rd_elem,
        .vec_addr, .vec_transpose, .vec_elems
    );

    // one lane per result column, A element broadcast
    for (genvar j = 0; j < `MAX_DIM; j++) begin : g_lane
        mmt_dot_lane i_lane (
            .clk, .rst_n,
            .a_elem     (rd_elem),
            .b_elem     (vec_elems[j]),
            .c_elem     (vec_elems[j]),
            .k_first, .k_step, .weight, .row_last,
            .term       (terms[j]),
            .term_valid (term_valid[j]),
            .term_last  (term_last[j])
        );
    end

    // lanes move in lockstep, lane 0 tags the row
    mmt_result_reducer i_reducer (
        .clk, .rst_n,
        .terms,
        .term_valid (term_valid[0]),
        .term_last  (term_last[0]),
        .out_valid, .out_value
    );

endmodule

`default_nettype wire

/* verification/mmt_checker.sv */
`include "mmt_defines.svh"
`default_nettype none

module mmt_checker (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     in_valid,
    input logic                     in_valid2,
    input logic                     out_valid,
    input logic signed [`OUT_W-1:0] out_value
);

    // result is a one cycle pulse
    a_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |=> !out_valid
    ) else $error("out_valid high for two cycles in a row");

    a_idle_zero: assert property (
        @(posedge clk) disable iff (!rst_n) !out_valid |-> (out_value == '0)
    ) else $error("out_value not zero while out_valid is low");

    // load and query phases never overlap
    a_no_overlap: assert property (
        @(posedge clk) disable iff (!rst_n) !(in_valid && in_valid2)
    ) else $error("in_valid and in_valid2 high together");

endmodule

bind mmt_top mmt_checker i_checker (
    .clk, .rst_n, .in_valid, .in_valid2, .out_valid, .out_value
);

`default_nettype wire

/* verification/mmt_scoreboard.sv */
`include "mmt_defines.svh"
`default_nettype none

module mmt_scoreboard
    import mmt_ctrl_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  logic [`ELEM_W-1:0]       matrix,
    input  logic [1:0]               matrix_size,
    input  logic                     in_valid2,
    input  logic [`MAT_W-1:0]        matrix_idx,
    input  logic [1:0]               mode,
    input  logic                     out_valid,
    input  logic signed [`OUT_W-1:0] out_value,
    input  logic                     exp_given,
    input  logic [`OUT_W-1:0]        exp_value,
    output int                       checked,
    output int                       failed
);

    int                mirror [`NUM_MATS][`MAX_DIM][`MAX_DIM];
    int                n = 2;
    int                load_cnt = 0;
    int                phase = 0;
    int                q_a;
    int                q_b;
    mode_e             q_mode;
    bit                loading = 1'b0;
    bit                busy = 1'b0;
    bit                file_given;
    logic [`OUT_W-1:0] file_value;
    logic [`OUT_W-1:0] want;

    initial begin
        checked = 0;
        failed = 0;
    end

    // sum over i, j of (op(A) op(B))[i][j] times C'[i][j]
    function automatic longint triple_product(input mode_e m, input int a,
                                              input int b, input int c);
        longint sum;
        longint t;
        int     ea;
        int     eb;
        int     ec;
        sum = 0;
        for (int i = 0; i < n; i++) begin
            for (int j = 0; j < n; j++) begin
                t = 0;
                for (int k = 0; k < n; k++) begin
                    ea = (m == MODE_ATB_C) ? mirror[a][k][i] : mirror[a][i][k];
                    eb = (m == MODE_ABT_C) ? mirror[b][j][k] : mirror[b][k][j];
                    t += ea * eb;
                end
                ec = (m == MODE_AB_CT) ? mirror[c][j][i] : mirror[c][i][j];
                sum += t * ec;
            end
        end
        return sum;
    endfunction

    // ------------------------------------------------------------------
    // port watcher
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        if (rst_n) begin
            // load and query never overlap
            if (in_valid && in_valid2) begin
                $display("in_valid and in_valid2 were high in the same cycle");
                failed++;
            end

            if (in_valid) begin
                if (!loading) begin
                    n = 2 << matrix_size;
                    load_cnt = 0;
                end
                mirror[load_cnt / (n * n)][(load_cnt / n) % n][load_cnt % n] = $signed(matrix);
                load_cnt++;
            end
            loading = in_valid;

            // mode and A, then B, then C
            if (in_valid2) begin
                if (phase == 0) begin
                    q_mode = mode_e'(mode);
                    q_a = matrix_idx;
                end else if (phase == 1) begin
                    q_b = matrix_idx;
                end else begin
                    want = (`OUT_W)'(triple_product(q_mode, q_a, q_b, matrix_idx));
                    file_given = exp_given;
                    file_value = exp_value;
                    busy = 1'b1;
                end
                phase++;
            end else begin
                phase = 0;
            end

            if (out_valid) begin
                if (!busy) begin
                    $display("out_valid pulsed with no query in flight");
                    failed++;
                end else begin
                    checked++;
                    busy = 1'b0;
                    if (out_value !== want) begin
                        $display("Fail query %0d: out_value %h, expected %h",
                                 checked, out_value, want);
                        failed++;
                    end else if (file_given && out_value !== file_value) begin
                        $display("Fail query %0d: out_value %h, file expects %h",
                                 checked, out_value, file_value);
                        failed++;
                    end else begin
                        $display("query %0d ok: out_value %h", checked, out_value);
                    end
                end
            end else if (out_value !== '0) begin
                $display("out_value is not zero while out_valid is low");
                failed++;
            end
        end
    end

endmodule

`default_nettype wire

/* verification/mmt_tb.sv */
`include "mmt_defines.svh"
`default_nettype none

module mmt_tb
    import mmt_ctrl_pkg::*;
();

    localparam int TIMEOUT = 400;

    logic                     clk;
    logic                     rst_n;
    logic                     in_valid;
    logic [`ELEM_W-1:0]       matrix;
    logic [1:0]               matrix_size;
    logic                     in_valid2;
    logic [`MAT_W-1:0]        matrix_idx;
    mode_e                    mode;
    logic                     out_valid;
    logic signed [`OUT_W-1:0] out_value;
    logic                     exp_given;
    logic [`OUT_W-1:0]        exp_value;
    int                       checked;
    int                       failed;
    int                       fd;
    logic [31:0]              rng;
    bit                       timed_out;

    mmt_top i_mmt_top (
        .clk, .rst_n,
        .in_valid, .matrix, .matrix_size,
        .in_valid2, .matrix_idx, .mode,
        .out_valid, .out_value
    );

    mmt_scoreboard i_scoreboard (
        .clk, .rst_n,
        .in_valid, .matrix, .matrix_size,
        .in_valid2, .matrix_idx, .mode,
        .out_valid, .out_value,
        .exp_given, .exp_value,
        .checked, .failed
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ------------------------------------------------------------------
    // load and query sequences
    // ------------------------------------------------------------------
    // explicit elements first, then fill byte, else xorshift data
    task automatic load_session(input int code, input logic [31:0] seed,
                                input logic [7:0] fill, input int nexp);
        int         n;
        int         r;
        logic [7:0] v;
        n = 2 << code;
        if (seed != 0) rng = seed;
        for (int e = 0; e < `NUM_MATS * n * n; e++) begin
            if (e < nexp) begin
                r = $fscanf(fd, "%h", v);
            end else if (fill != 0) begin
                v = fill;
            end else begin
                rng = xorshift(rng);
                v = rng[15:8];
            end
            @(negedge clk);
            in_valid = 1'b1;
            matrix = v;
            matrix_size = 2'(code);
        end
        @(negedge clk);
        in_valid = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    task automatic run_query(input int m, input int a, input int b, input int c,
                             input bit given, input logic [`OUT_W-1:0] value);
        int cycles;
        exp_given = given;
        exp_value = value;
        @(negedge clk);
        in_valid2 = 1'b1;
        mode = mode_e'(m);
        matrix_idx = (`MAT_W)'(a);
        @(negedge clk);
        matrix_idx = (`MAT_W)'(b);
        @(negedge clk);
        matrix_idx = (`MAT_W)'(c);
        @(negedge clk);
        in_valid2 = 1'b0;
        cycles = 0;
        while (!out_valid && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!out_valid) begin
            $display("query %0d %0d %0d %0d gave no result within %0d cycles",
                     m, a, b, c, TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        string             line;
        int                r;
        int                code;
        int                nexp;
        int                m;
        int                a;
        int                b;
        int                c;
        int                queries;
        logic [31:0]       seed;
        logic [7:0]        fill;
        logic [`OUT_W-1:0] value;
        rst_n = 1'b0;
        in_valid = 1'b0;
        matrix = '0;
        matrix_size = '0;
        in_valid2 = 1'b0;
        matrix_idx = '0;
        mode = MODE_AB_C;
        exp_given = 1'b0;
        exp_value = '0;
        rng = 32'h91af_846b;
        timed_out = 1'b0;
        queries = 0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        fd = $fopen("verification/mmt_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open verification/mmt_testdata.txt");
        end else begin
            while (!timed_out && $fgets(line, fd) > 0) begin
                if (line.getc(0) == "L") begin
                    r = $sscanf(line.substr(1, line.len() - 1), "%d %h %h %d",
                                code, seed, fill, nexp);
                    load_session(code, seed, fill, nexp);
                end else if (line.getc(0) == "Q") begin
                    r = $sscanf(line.substr(1, line.len() - 1), "%d %d %d %d %h",
                                m, a, b, c, value);
                    run_query(m, a, b, c, r == 5, value);
                    queries++;
                end
            end
            $fclose(fd);
        end
        repeat (4) @(negedge clk);
        $display("%0d queries sent, %0d checked, %0d failures", queries, checked, failed);
        if (fd == 0 || timed_out || failed != 0 || checked != queries) begin
            $display("Regression failed");
        end else begin
            $display("Regression passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/mmt_testdata.txt */
# L size_code seed fill explicit_count, explicit elements follow in hex
# Q mode a b c [expected out_value, 34-bit two's complement hex]
L 0 0 00 32
01 02 03 04 ff 00 02 05
03 fe 01 01 02 01 00 fd
07 f8 05 06 80 7f 00 01
04 04 fc 04 09 00 00 09
Q 0 0 1 2 00000000e
Q 1 0 1 2 00000000b
Q 2 0 1 2 3fffffffc
Q 3 0 1 2 00000001d
Q 0 4 4 4 0000004ac
Q 1 5 5 5 3ffc0be82
Q 2 6 7 3
Q 3 5 6 7
Q 0 7 7 0
Q 1 3 2 1
L 1 91af846b 00 0
Q 0 1 2 3
Q 1 1 2 3
Q 2 1 2 3
Q 3 1 2 3
Q 0 5 5 5
Q 3 0 7 4
Q 2 6 6 6
Q 1 4 0 2
Q 0 2 3 1
Q 3 7 7 7
L 2 0 80 0
Q 0 0 1 2 3c0000000
Q 1 3 4 5 3c0000000
Q 2 6 7 0 3c0000000
Q 3 1 2 3 3c0000000
Q 0 7 7 7 3c0000000
Q 1 2 2 2 3c0000000
Q 2 4 5 6 3c0000000
Q 3 5 0 7 3c0000000
Q 0 6 3 1 3c0000000
Q 1 0 0 0 3c0000000

/* compile.f */
+incdir+source
source/mmt_mem_pkg.sv
source/mmt_ctrl_pkg.sv
source/mmt_matrix_store.sv
source/mmt_sequencer.sv
source/mmt_dot_lane.sv
source/mmt_result_reducer.sv
source/mmt_top.sv
verification/mmt_checker.sv
verification/mmt_scoreboard.sv
verification/mmt_tb.sv

/* run.sh */
#!/bin/sh
# build and run the regression with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module mmt_tb -f compile.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vmmt_tb +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0
